// ==== snowflake_soc.f ====
src/snowflake_pkg.sv
src/snowflake_mem_if.sv
src/snowflake_system_bus.sv
src/snowflake_main_memory.sv
src/snowflake_system_regs.sv
src/snowflake_soc.sv
dv/tb_snowflake_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the snowflake_soc testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_snowflake_soc \
    -f snowflake_soc.f \
    -o sim_snowflake_soc

output=$(./obj_dir/sim_snowflake_soc 2>&1) || { echo "$output"; exit 1; }
echo "$output"

if ! grep -q "Everything OK" <<< "$output"; then
    echo "Simulation did not report a pass" >&2
    exit 1
fi

// ==== dv/tb_snowflake_soc.sv ====
/* Testbench for the snowflake memory subsystem
   Table-driven fetch, data and system register accesses against a model */

`timescale 1ns/1ps

module tb_snowflake_soc;
    import snowflake_pkg::*;

    localparam int MAX_ROWS  = 32;
    localparam int RST_LIMIT = 20;
    localparam int RUN_LIMIT = 2000;

    // Port flags, bit 0 fetch, bit 1 data read, bit 2 data write
    localparam logic [2:0] K_FE = 3'b001;
    localparam logic [2:0] K_RD = 3'b010;
    localparam logic [2:0] K_WR = 3'b100;
    localparam logic [2:0] K_FR = 3'b011;
    localparam logic [2:0] K_FW = 3'b101;

    logic       clk;
    logic       rstz;
    word_t      instr_addr;
    logic       instr_req;
    word_t      instr_data;
    logic       instr_gnt;
    word_t      data_addr;
    word_t      data_wr_data;
    byte_mask_t data_wr_mask;
    logic       data_rd_req;
    logic       data_wr_req;
    word_t      data_rd_data;
    logic       data_gnt;
    word_t      gpio_out;

    // Stimulus table
    string      row_name   [MAX_ROWS];
    logic [2:0] row_kind   [MAX_ROWS];
    word_t      row_addr   [MAX_ROWS];
    word_t      row_faddr  [MAX_ROWS];
    word_t      row_wdata  [MAX_ROWS];
    byte_mask_t row_mask   [MAX_ROWS];
    logic       row_dgnt   [MAX_ROWS];
    logic       row_igrant [MAX_ROWS];
    int         n_rows;
    integer     seed;

    // Reference model of both targets
    word_t mem_model [MEM_WORDS];
    word_t sys_model [SYS_WORDS];

    // Port names match the DUT one to one
    snowflake_soc u_snowflake_soc (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for three cycles, released on a falling edge
    initial begin
        rstz = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstz = 1'b1;
    end

    initial begin : watchdog
        for (int c = 0; c < RUN_LIMIT; c++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", RUN_LIMIT);
        $display("Something failed");
        $fatal(1, "run timeout");
    end

    // ============================================================
    // Model and checks

    function automatic word_t model_read(input word_t addr);
        if (!addr[12]) begin
            return mem_model[addr[11:2]];
        end
        if (addr[7:2] == 6'd0) begin
            return SYS_ID_VALUE;
        end
        return sys_model[addr[7:2]];
    endfunction

    task automatic model_write(input word_t addr, input word_t data, input byte_mask_t mask);
        word_t cur;
        cur = model_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                cur[8*b +: 8] = data[8*b +: 8];
            end
        end
        if (!addr[12]) begin
            mem_model[addr[11:2]] = cur;
        end else if (addr[11:8] == 4'h0 && addr[7:2] != 6'd0) begin
            sys_model[addr[7:2]] = cur;
        end
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
            $display("Something failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic [2:0] kind, input word_t addr,
                           input word_t faddr, input byte_mask_t mask,
                           input logic dgnt, input logic igrant);
        row_name[n_rows]   = name;
        row_kind[n_rows]   = kind;
        row_addr[n_rows]   = addr;
        row_faddr[n_rows]  = faddr;
        row_wdata[n_rows]  = $random(seed);
        row_mask[n_rows]   = mask;
        row_dgnt[n_rows]   = dgnt;
        row_igrant[n_rows] = igrant;
        n_rows++;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (u_snowflake_soc.rstz !== 1'b1) begin
            if (cycles == RST_LIMIT) begin
                $display("Reset was not released within %0d cycles", RST_LIMIT);
                $display("Something failed");
                $fatal(1, "reset timeout");
            end
            @(posedge clk);
            cycles++;
        end
        // One idle edge out of reset
        @(posedge clk);
        @(negedge clk);
    endtask

    // ============================================================
    // Row execution, driven on the falling edge

    task automatic run_row(input int r);
        word_t exp_data;
        word_t exp_fetch;
        instr_req    = row_kind[r][0];
        instr_addr   = row_faddr[r];
        data_rd_req  = row_kind[r][1];
        data_wr_req  = row_kind[r][2];
        data_addr    = row_addr[r];
        data_wr_data = row_wdata[r];
        data_wr_mask = row_mask[r];
        exp_data     = model_read(row_addr[r]);
        exp_fetch    = model_read(row_faddr[r]);
        @(posedge clk);
        @(negedge clk);
        data_rd_req = 1'b0;
        data_wr_req = 1'b0;
        if (row_kind[r][2] && row_dgnt[r]) begin
            model_write(row_addr[r], row_wdata[r], row_mask[r]);
        end
        check_value({row_name[r], " data_gnt"}, word_t'(row_dgnt[r]), word_t'(data_gnt));
        check_value({row_name[r], " instr_gnt"}, word_t'(row_igrant[r]), word_t'(instr_gnt));
        if (row_kind[r][1] && row_dgnt[r]) begin
            check_value({row_name[r], " data_rd_data"}, exp_data, data_rd_data);
        end
        if (row_kind[r][0] && row_igrant[r]) begin
            check_value({row_name[r], " instr_data"}, exp_fetch, instr_data);
        end
        // Fetch held back by a memory data access, kept asserted
        if (row_kind[r][0] && !row_igrant[r]) begin
            @(posedge clk);
            @(negedge clk);
            check_value({row_name[r], " late instr_gnt"}, 32'd1, word_t'(instr_gnt));
            check_value({row_name[r], " late instr_data"}, model_read(row_faddr[r]),
                        instr_data);
        end
        instr_req = 1'b0;
        check_value({row_name[r], " gpio_out"}, sys_model[SYS_GPIO_WORD], gpio_out);
    endtask

    // ============================================================
    // Main sequence

    initial begin
        seed         = 32'ha104;
        n_rows       = 0;
        instr_addr   = '0;
        instr_req    = 1'b0;
        data_addr    = '0;
        data_wr_data = '0;
        data_wr_mask = '0;
        data_rd_req  = 1'b0;
        data_wr_req  = 1'b0;
        for (int i = 0; i < SYS_WORDS; i++) begin
            sys_model[i] = '0;
        end

        //       name                kind  addr      fetch     mask  dgnt  igrant
        add_row("mem_wr_0",          K_WR, 32'h0000, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("mem_wr_4",          K_WR, 32'h0004, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("mem_wr_100",        K_WR, 32'h0100, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("mem_wr_ffc",        K_WR, 32'h0ffc, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("mem_wr_4_part",     K_WR, 32'h0004, 32'h0000, 4'h5, 1'b1, 1'b0);
        add_row("mem_wr_100_part",   K_WR, 32'h0100, 32'h0000, 4'h8, 1'b1, 1'b0);
        add_row("mem_rd_4",          K_RD, 32'h0004, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("mem_rd_100",        K_RD, 32'h0100, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("fetch_0",           K_FE, 32'h0000, 32'h0000, 4'hf, 1'b0, 1'b1);
        add_row("fetch_4",           K_FE, 32'h0000, 32'h0004, 4'hf, 1'b0, 1'b1);
        add_row("fetch_mem_rd",      K_FR, 32'h0000, 32'h0100, 4'hf, 1'b1, 1'b0);
        add_row("fetch_mem_wr",      K_FW, 32'h0ffc, 32'h0004, 4'h3, 1'b1, 1'b0);
        add_row("mem_rd_ffc",        K_RD, 32'h0ffc, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("fetch_sys_rd",      K_FR, 32'h1000, 32'h0100, 4'hf, 1'b1, 1'b1);
        add_row("sys_wr_id",         K_WR, 32'h1000, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("sys_rd_id",         K_RD, 32'h1000, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("sys_wr_gpio",       K_WR, 32'h1004, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("sys_wr_gpio_part",  K_WR, 32'h1004, 32'h0000, 4'h2, 1'b1, 1'b0);
        add_row("sys_wr_scr_2",      K_WR, 32'h1008, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("fetch_sys_wr",      K_FW, 32'h10fc, 32'h0ffc, 4'hc, 1'b1, 1'b1);
        add_row("sys_rd_scr_2",      K_RD, 32'h1008, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("sys_rd_scr_63",     K_RD, 32'h10fc, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("undec_wr_1104",     K_WR, 32'h1104, 32'h0000, 4'hf, 1'b0, 1'b0);
        add_row("undec_wr_1100",     K_WR, 32'h1100, 32'h0000, 4'hf, 1'b0, 1'b0);
        add_row("undec_rd_1f04",     K_RD, 32'h1f04, 32'h0000, 4'hf, 1'b0, 1'b0);
        add_row("mem_rd_100_after",  K_RD, 32'h0100, 32'h0000, 4'hf, 1'b1, 1'b0);
        add_row("sys_rd_gpio",       K_RD, 32'h1004, 32'h0000, 4'hf, 1'b1, 1'b0);

        // Grants stay low while reset is held
        @(posedge clk);
        @(negedge clk);
        check_value("reset data_gnt", 32'd0, word_t'(data_gnt));
        check_value("reset instr_gnt", 32'd0, word_t'(instr_gnt));
        wait_reset_release();
        check_value("idle data_gnt", 32'd0, word_t'(data_gnt));
        check_value("idle instr_gnt", 32'd0, word_t'(instr_gnt));
        check_value("idle gpio_out", 32'd0, gpio_out);

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== src/snowflake_soc.sv ====
/* Memory subsystem top level
   System bus with main memory and the system register block behind it */

`timescale 1ns/1ps

module snowflake_soc (
    input  logic                      clk,
    input  logic                      rstz,
    // Core instruction port
    input  snowflake_pkg::word_t      instr_addr,
    input  logic                      instr_req,
    output snowflake_pkg::word_t      instr_data,
    output logic                      instr_gnt,
    // Core data port
    input  snowflake_pkg::word_t      data_addr,
    input  snowflake_pkg::word_t      data_wr_data,
    input  snowflake_pkg::byte_mask_t data_wr_mask,
    input  logic                      data_rd_req,
    input  logic                      data_wr_req,
    output snowflake_pkg::word_t      data_rd_data,
    output logic                      data_gnt,
    // General-purpose output register
    output snowflake_pkg::word_t      gpio_out
);

    // One target bus per region
    snowflake_mem_if mem_bus ();
    snowflake_mem_if sys_bus ();

    snowflake_system_bus u_system_bus (
        .clk          (clk),
        .rstz         (rstz),
        .instr_addr   (instr_addr),
        .instr_req    (instr_req),
        .data_addr    (data_addr),
        .data_wr_data (data_wr_data),
        .data_wr_mask (data_wr_mask),
        .data_rd_req  (data_rd_req),
        .data_wr_req  (data_wr_req),
        .instr_data   (instr_data),
        .instr_gnt    (instr_gnt),
        .data_rd_data (data_rd_data),
        .data_gnt     (data_gnt),
        .mem          (mem_bus.bus),
        .sys          (sys_bus.bus)
    );

    snowflake_main_memory u_main_memory (
        .clk  (clk),
        .port (mem_bus.target)
    );

    snowflake_system_regs u_system_regs (
        .clk      (clk),
        .rstz     (rstz),
        .port     (sys_bus.target),
        .gpio_out (gpio_out)
    );

endmodule

// ==== src/snowflake_system_regs.sv ====
/* System register block with the platform ID, the GPIO output
   register and scratch words */

`timescale 1ns/1ps

module snowflake_system_regs (
    input  logic                  clk,
    input  logic                  rstz,
    snowflake_mem_if.target       port,
    output snowflake_pkg::word_t  gpio_out
);
    import snowflake_pkg::*;

    word_t regs [SYS_WORDS];

    logic [$clog2(SYS_WORDS)-1:0] word_idx;
    logic                         is_id_word;

    // Address bits 7:2 pick the word
    assign word_idx   = port.addr[$clog2(SYS_WORDS)+1:2];
    assign is_id_word = (word_idx == SYS_ID_WORD);

    // ============================================================
    // Register file

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 0; i < SYS_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (port.en && port.wr_en && !is_id_word) begin
            // ID word is read-only, writes to it are dropped
            for (int b = 0; b < 4; b++) begin
                if (port.wr_mask[b]) begin
                    regs[word_idx][8*b +: 8] <= port.wr_data[8*b +: 8];
                end
            end
        end
    end

    // ============================================================
    // Read port

    // Registered, holds until the next enabled cycle
    always_ff @(posedge clk) begin
        if (port.en) begin
            port.rd_data <= is_id_word ? SYS_ID_VALUE : regs[word_idx];
        end
    end

    // GPIO straight from its register
    assign gpio_out = regs[SYS_GPIO_WORD];

endmodule

// ==== src/snowflake_main_memory.sv ====
/* Main memory, 4 KB single port
   Byte-masked writes and a registered read-before-write port */

`timescale 1ns/1ps

module snowflake_main_memory (
    input  logic                  clk,
    snowflake_mem_if.target       port
);
    import snowflake_pkg::*;

    // Storage, no reset so it maps onto a block RAM
    word_t mem_array [MEM_WORDS];

    logic [$clog2(MEM_WORDS)-1:0] word_idx;

    // Byte address to word index
    assign word_idx = port.addr[$clog2(MEM_WORDS)+1:2];

    // ============================================================
    // Read port

    // Old contents are returned on a write cycle
    always_ff @(posedge clk) begin
        if (port.en) begin
            port.rd_data <= mem_array[word_idx];
        end
    end

    // ============================================================
    // Write port

    always_ff @(posedge clk) begin
        if (port.en && port.wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (port.wr_mask[b]) begin
                    mem_array[word_idx][8*b +: 8] <= port.wr_data[8*b +: 8];
                end
            end
        end
    end

    // ============================================================
    // Checks

    // The bus only raises wr_en for an enabled access
    a_wr_needs_en: assert property (@(posedge clk)
        port.wr_en |-> port.en);

endmodule

// ==== src/snowflake_system_bus.sv ====
/* System bus routing the core fetch and data ports to main memory and
   the system register block, with data taking priority at the memory */

`timescale 1ns/1ps

module snowflake_system_bus (
    input  logic                      clk,
    input  logic                      rstz,
    input  snowflake_pkg::word_t      instr_addr,
    input  logic                      instr_req,
    input  snowflake_pkg::word_t      data_addr,
    input  snowflake_pkg::word_t      data_wr_data,
    input  snowflake_pkg::byte_mask_t data_wr_mask,
    input  logic                      data_rd_req,
    input  logic                      data_wr_req,
    output snowflake_pkg::word_t      instr_data,
    output logic                      instr_gnt,
    output snowflake_pkg::word_t      data_rd_data,
    output logic                      data_gnt,
    snowflake_mem_if.bus              mem,
    snowflake_mem_if.bus              sys
);
    import snowflake_pkg::*;

    logic is_system;
    logic is_sys_page;
    logic mem_data_access;
    logic sys_data_access;

    logic mem_instr_gnt;
    logic mem_data_gnt;
    logic sys_data_gnt;

    // ============================================================
    // Address decode

    assign is_system   = data_addr[SYSTEM_SEL_BIT];
    assign is_sys_page = (data_addr[11:8] == SYS_PAGE);

    assign mem_data_access = (data_rd_req | data_wr_req) & ~is_system;
    // Other system pages fall through with no enable
    assign sys_data_access = (data_rd_req | data_wr_req) & is_system & is_sys_page;

    // ============================================================
    // Target ports

    // Data wins the memory port over a fetch
    always_comb begin
        mem.en      = instr_req | mem_data_access;
        mem.wr_en   = data_wr_req & ~is_system;
        mem.addr    = mem_data_access ? data_addr : instr_addr;
        mem.wr_data = data_wr_data;
        mem.wr_mask = data_wr_mask;
    end

    always_comb begin
        sys.en      = sys_data_access;
        sys.wr_en   = data_wr_req & is_system & is_sys_page;
        sys.addr    = data_addr;
        sys.wr_data = data_wr_data;
        sys.wr_mask = data_wr_mask;
    end

    // ============================================================
    // Grants

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            mem_instr_gnt <= 1'b0;
            mem_data_gnt  <= 1'b0;
            sys_data_gnt  <= 1'b0;
        end else begin
            mem_instr_gnt <= instr_req & ~mem_data_access;
            mem_data_gnt  <= mem_data_access;
            sys_data_gnt  <= sys_data_access;
        end
    end

    // Fetches only ever come from memory
    assign instr_gnt  = mem_instr_gnt;
    assign instr_data = mem.rd_data;

    assign data_gnt     = mem_data_gnt | sys_data_gnt;
    assign data_rd_data = sys_data_gnt ? sys.rd_data : mem.rd_data;

    // ============================================================
    // Checks

    // Core never reads and writes in the same cycle
    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rstz)
        !(data_rd_req && data_wr_req));

    // No fetch buffer, so a fetch held back by data must stay requested
    a_held_fetch_kept: assert property (@(posedge clk) disable iff (!rstz)
        (instr_req && mem_data_access) |=> instr_req);

    a_mem_addr_range: assert property (@(posedge clk) disable iff (!rstz)
        mem.en |-> ((mem.addr >> 2) < MEM_WORDS));

endmodule

// ==== src/snowflake_mem_if.sv ====
/* Single-port target bus
   The system bus drives the request side, the target returns read data */

`timescale 1ns/1ps

interface snowflake_mem_if;
    import snowflake_pkg::*;

    // Request side
    word_t      addr;
    word_t      wr_data;
    logic       en;
    logic       wr_en;
    byte_mask_t wr_mask;

    // Response, valid one cycle after en
    word_t      rd_data;

    modport bus (
        output addr, wr_data, en, wr_en, wr_mask,
        input  rd_data
    );

    modport target (
        input  addr, wr_data, en, wr_en, wr_mask,
        output rd_data
    );

endinterface

// ==== src/snowflake_pkg.sv ====
/* Shared types and memory map for the snowflake memory subsystem
   Word and mask types, region decode constants and system register indices */

package snowflake_pkg;

    // ============================================================
    // Types

    // Data and address words share one width
    typedef logic [31:0] word_t;

    // One bit per byte lane
    typedef logic [3:0] byte_mask_t;

    // ============================================================
    // Memory map

    // Main memory depth, 4 KB at 0x0000
    localparam int MEM_WORDS = 1024;

    // System register block depth, 256 bytes at 0x1000
    localparam int SYS_WORDS = 64;

    // Address bit that selects the system region
    localparam int SYSTEM_SEL_BIT = 12;

    // Page within the system region, address bits 11:8
    localparam logic [3:0] SYS_PAGE = 4'h0;

    // ============================================================
    // System register indices

    localparam int SYS_ID_WORD   = 0;
    localparam int SYS_GPIO_WORD = 1;

    // Read-only platform identifier
    localparam word_t SYS_ID_VALUE = 32'h534E_4F57;

endpackage
